// File: adc_pkg.sv
`include "scope_defs.svh"

package adc_pkg;

  // one axis value from the converter
  typedef logic [`ADC_BITS-1:0] adc_data_t;

  // color bits, red in bit 2, green in bit 1, blue in bit 0
  typedef logic [2:0] adc_rgb_t;

endpackage

// File: adc_xy_capture.sv
`timescale 1ns/1ps

module adc_xy_capture (
  input  logic               clk,
  input  logic               reset,
  input  adc_pkg::adc_data_t adc_x,
  input  adc_pkg::adc_data_t adc_y,
  input  adc_pkg::adc_rgb_t  adc_rgb,
  input  logic               adc_strobe,
  adc_sample_if.source       smp
);

  logic               full;
  adc_pkg::adc_data_t hold_x;
  adc_pkg::adc_data_t hold_y;
  adc_pkg::adc_rgb_t  hold_rgb;

  logic take;
  logic load;

  // sample leaves on the handshake edge
  assign take = full && smp.ready;
  // strobes while full are dropped
  assign load = adc_strobe && !full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (take) begin
      full <= 1'b0;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (load) begin
      hold_x   <= adc_x;
      hold_y   <= adc_y;
      hold_rgb <= adc_rgb;
    end
  end

  assign smp.valid = full;
  assign smp.x     = hold_x;
  assign smp.y     = hold_y;
  assign smp.rgb   = hold_rgb;

endmodule

// File: adc_xy_scope.sv
`timescale 1ns/1ps
`include "scope_defs.svh"

module adc_xy_scope (
  input  logic               clk,
  input  logic               reset,
  input  adc_pkg::adc_data_t adc_x,
  input  adc_pkg::adc_data_t adc_y,
  input  adc_pkg::adc_rgb_t  adc_rgb,
  input  logic               adc_strobe,
  output gfx_pkg::channel_t  vga_red,
  output gfx_pkg::channel_t  vga_grn,
  output gfx_pkg::channel_t  vga_blu,
  output logic               vga_hsync,
  output logic               vga_vsync
);

  adc_sample_if adc_smp ();
  gfx_pixel_if  clr_pix ();
  gfx_pixel_if  draw_pix ();

  gfx_pkg::start_state_t                start_state;
  logic [$clog2(`SETTLE_CYCLES+1)-1:0]  settle_count;
  logic                                 clr_last;
  logic                                 enable;
  logic                                 run;

  adc_pkg::adc_data_t adc_flip_x;
  adc_pkg::adc_data_t adc_half_y;
  logic               in_range;
  gfx_pkg::pixel_t    adc_color;

  adc_xy_capture u_capture (
    .clk        (clk),
    .reset      (reset),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_rgb    (adc_rgb),
    .adc_strobe (adc_strobe),
    .smp        (adc_smp.source)
  );

  gfx_clear u_clear (
    .clk   (clk),
    .reset (reset),
    .pix   (clr_pix.source),
    .last  (clr_last)
  );

  // mirror x, halve both axes into the 32x24 buffer
  assign adc_flip_x = ~adc_smp.x;
  assign adc_half_y = adc_smp.y >> 1;
  assign in_range   = adc_half_y < `FB_HEIGHT;
  // each color bit spread over its channel
  assign adc_color  = {{4{adc_smp.rgb[2]}}, {4{adc_smp.rgb[1]}}, {4{adc_smp.rgb[0]}}};

  assign run = start_state == gfx_pkg::START_RUN;

  // clear source until the display runs
  assign draw_pix.valid = run ? (adc_smp.valid && in_range) : clr_pix.valid;
  assign draw_pix.x     = run ? gfx_pkg::fb_x_t'(adc_flip_x >> 1) : clr_pix.x;
  assign draw_pix.y     = run ? gfx_pkg::fb_y_t'(adc_half_y) : clr_pix.y;
  assign draw_pix.color = run ? adc_color : clr_pix.color;
  assign clr_pix.ready  = !run && draw_pix.ready;
  // off-screen or early samples are taken and thrown away
  assign adc_smp.ready  = !run || !in_range || draw_pix.ready;

  gfx_vga_fade u_vga (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .draw      (draw_pix.sink),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  // startup: clear, settle, run
  always_ff @(posedge clk) begin
    if (reset) begin
      start_state  <= gfx_pkg::START_CLEAR;
      settle_count <= '0;
    end else begin
      case (start_state)
        gfx_pkg::START_CLEAR: begin
          if (clr_last && clr_pix.ready) begin
            start_state <= gfx_pkg::START_SETTLE;
          end
        end
        gfx_pkg::START_SETTLE: begin
          if (settle_count == `SETTLE_CYCLES - 1) begin
            start_state <= gfx_pkg::START_RUN;
          end else begin
            settle_count <= settle_count + 1'b1;
          end
        end
        default: begin
          start_state <= gfx_pkg::START_RUN;
        end
      endcase
    end
  end

  assign enable = run;

endmodule

// File: adc_xy_scope_checker.sv
`timescale 1ns/1ps
`include "scope_defs.svh"

module adc_xy_scope_checker (
  input logic            clk,
  input logic            reset,
  input logic            enable,
  input logic            draw_valid,
  input logic            draw_ready,
  input gfx_pkg::fb_x_t  draw_x,
  input gfx_pkg::fb_y_t  draw_y,
  input gfx_pkg::pixel_t draw_color,
  input logic            vga_hsync,
  input logic            vga_vsync
);

  // two clk cycles per pixel slot
  localparam int VSYNC_CLKS = 2 * `V_SYNC * `H_TOTAL;

  logic [15:0] vsync_low;

  always_ff @(posedge clk) begin
    if (reset || vga_vsync) begin
      vsync_low <= '0;
    end else begin
      vsync_low <= vsync_low + 1'b1;
    end
  end

  draw_hold: assert property (@(posedge clk) disable iff (reset)
    draw_valid && !draw_ready |=>
      draw_valid && $stable(draw_x) && $stable(draw_y) && $stable(draw_color))
    else $error("draw pixel changed while stalled");

  sync_idle: assert property (@(posedge clk) disable iff (reset)
    !enable |-> vga_hsync && vga_vsync)
    else $error("sync active while the display is off");

  vsync_width: assert property (@(posedge clk) disable iff (reset)
    $rose(vga_vsync) |-> vsync_low == VSYNC_CLKS)
    else $error("vsync pulse lasted %0d clk cycles", vsync_low);

endmodule

// File: adc_xy_scope_tests.txt
# adc_x adc_y rgb frames drop exp_x exp_y exp_pixel, all hex
# frames 0 strobes the sample in the same blanking as the next record
3f 00 7 11 0 00 00 fff
00 2f 4 03 0 1f 17 f00
20 30 7 02 1 00 00 000
0c 3f 5 01 1 00 00 000
10 10 2 00 0 17 08 0f0
2a 15 1 04 0 0a 0a 00f
1f 2e 5 02 0 10 17 f0f
01 2e 0 02 0 1f 17 000
05 05 3 02 0 1d 02 0ff
3e 01 6 02 0 00 00 ff0
3f 2f 7 00 0 00 17 fff
00 00 3 00 0 1f 00 0ff
20 38 1 01 1 00 00 000
1e 1e 4 01 0 10 0f f00

// File: files.f
+incdir+.
adc_pkg.sv
gfx_pkg.sv
scope_ifs.sv
adc_xy_capture.sv
gfx_clear.sv
gfx_vga_fade.sv
adc_xy_scope.sv
adc_xy_scope_checker.sv
tb_adc_xy_scope.sv

// File: gfx_clear.sv
`timescale 1ns/1ps
`include "scope_defs.svh"

module gfx_clear (
  input  logic         clk,
  input  logic         reset,
  gfx_pixel_if.source  pix,
  output logic         last
);

  gfx_pkg::clear_state_t state;
  gfx_pkg::fb_x_t        x;
  gfx_pkg::fb_y_t        y;

  logic end_of_line;
  logic end_of_frame;

  assign end_of_line  = x == gfx_pkg::fb_x_t'(`FB_WIDTH - 1);
  assign end_of_frame = end_of_line && (y == gfx_pkg::fb_y_t'(`FB_HEIGHT - 1));

  // raster walk, one step per accepted pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= gfx_pkg::CLEAR_RUN;
      x     <= '0;
      y     <= '0;
    end else if (state == gfx_pkg::CLEAR_RUN && pix.ready) begin
      if (end_of_line) begin
        x <= '0;
        if (end_of_frame) begin
          state <= gfx_pkg::CLEAR_DONE;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  assign pix.valid = state == gfx_pkg::CLEAR_RUN;
  assign pix.x     = x;
  assign pix.y     = y;
  // black
  assign pix.color = '0;

  assign last = pix.valid && end_of_frame;

endmodule

// File: gfx_pkg.sv
`include "scope_defs.svh"

package gfx_pkg;

  // framebuffer coordinates
  typedef logic [$clog2(`FB_WIDTH)-1:0] fb_x_t;
  typedef logic [$clog2(`FB_HEIGHT)-1:0] fb_y_t;
  typedef logic [$clog2(`FB_WIDTH * `FB_HEIGHT)-1:0] fb_addr_t;

  // red nibble high, then green, then blue
  typedef logic [3:0] channel_t;
  typedef logic [3*$bits(channel_t)-1:0] pixel_t;

  typedef enum logic {
    CLEAR_RUN,
    CLEAR_DONE
  } clear_state_t;

  typedef enum logic [1:0] {
    START_CLEAR,
    START_SETTLE,
    START_RUN
  } start_state_t;

endpackage

// File: gfx_vga_fade.sv
`timescale 1ns/1ps
`include "scope_defs.svh"

module gfx_vga_fade (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  gfx_pixel_if.sink         draw,
  output gfx_pkg::channel_t vga_red,
  output gfx_pkg::channel_t vga_grn,
  output gfx_pkg::channel_t vga_blu,
  output logic              vga_hsync,
  output logic              vga_vsync
);

  gfx_pkg::pixel_t fb_mem [`FB_WIDTH * `FB_HEIGHT];

  // scan state
  logic                         phase;
  logic [$clog2(`H_TOTAL)-1:0]  h_count;
  logic [$clog2(`V_TOTAL)-1:0]  v_count;

  logic              slot;
  logic              wb_cycle;
  logic              scan_visible;
  logic              hsync_now;
  logic              vsync_now;
  gfx_pkg::fb_addr_t scan_addr;
  gfx_pkg::fb_addr_t draw_addr;
  logic              draw_fire;

  // read and output pipeline
  gfx_pkg::pixel_t   rd_data;
  gfx_pkg::pixel_t   faded;
  logic              visible_d1;
  logic              hsync_d1;
  logic              vsync_d1;

  // slot on phase 0, write-back on phase 1
  assign slot = !phase;

  assign scan_visible = (h_count < `FB_WIDTH) && (v_count < `FB_HEIGHT);
  assign scan_addr    = gfx_pkg::fb_addr_t'(v_count * `FB_WIDTH + h_count);
  assign draw_addr    = gfx_pkg::fb_addr_t'(draw.y * `FB_WIDTH + draw.x);

  // active-low sync windows
  assign hsync_now = !((h_count >= `FB_WIDTH + `H_FRONT) &&
                       (h_count <  `FB_WIDTH + `H_FRONT + `H_SYNC));
  assign vsync_now = !((v_count >= `FB_HEIGHT + `V_FRONT) &&
                       (v_count <  `FB_HEIGHT + `V_FRONT + `V_SYNC));

  // write port belongs to the fade during visible write-back cycles
  assign wb_cycle   = phase && scan_visible && enable;
  assign draw.ready = !wb_cycle;
  assign draw_fire  = draw.valid && draw.ready;

  // saturating decay per channel
  always_comb begin
    for (int c = 0; c < 3; c++) begin
      if (rd_data[c*4 +: 4] >= gfx_pkg::channel_t'(`FADE_STEP)) begin
        faded[c*4 +: 4] = rd_data[c*4 +: 4] - gfx_pkg::channel_t'(`FADE_STEP);
      end else begin
        faded[c*4 +: 4] = '0;
      end
    end
  end

  // pixel-slot divider and raster counters
  always_ff @(posedge clk) begin
    if (reset) begin
      phase   <= 1'b0;
      h_count <= '0;
      v_count <= '0;
    end else begin
      phase <= !phase;
      if (phase) begin
        if (h_count == `H_TOTAL - 1) begin
          h_count <= '0;
          if (v_count == `V_TOTAL - 1) begin
            v_count <= '0;
          end else begin
            v_count <= v_count + 1'b1;
          end
        end else begin
          h_count <= h_count + 1'b1;
        end
      end
    end
  end

  // single write port, fade and draw never collide
  always_ff @(posedge clk) begin
    if (wb_cycle) begin
      fb_mem[scan_addr] <= faded;
    end else if (draw_fire) begin
      fb_mem[draw_addr] <= draw.color;
    end
  end

  // scan read, a draw to the same address wins so it survives write-back
  always_ff @(posedge clk) begin
    if (slot) begin
      if (draw_fire && draw_addr == scan_addr) begin
        rd_data <= draw.color;
      end else begin
        rd_data <= fb_mem[scan_addr];
      end
    end
  end

  // two-stage output, 2 clk behind the scan position
  always_ff @(posedge clk) begin
    if (reset) begin
      visible_d1 <= 1'b0;
      hsync_d1   <= 1'b1;
      vsync_d1   <= 1'b1;
      vga_red    <= '0;
      vga_grn    <= '0;
      vga_blu    <= '0;
      vga_hsync  <= 1'b1;
      vga_vsync  <= 1'b1;
    end else begin
      visible_d1 <= scan_visible;
      hsync_d1   <= hsync_now;
      vsync_d1   <= vsync_now;
      if (enable && visible_d1) begin
        vga_red <= rd_data[11:8];
        vga_grn <= rd_data[7:4];
        vga_blu <= rd_data[3:0];
      end else begin
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end
      // display off keeps both syncs inactive
      vga_hsync <= enable ? hsync_d1 : 1'b1;
      vga_vsync <= enable ? vsync_d1 : 1'b1;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module tb_adc_xy_scope -f files.f -o sim_tb \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Simulation PASSED$" \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }

// File: scope_defs.svh
`ifndef SCOPE_DEFS_SVH
`define SCOPE_DEFS_SVH

// adc sample width per axis
`define ADC_BITS 6

// framebuffer size in pixels
`define FB_WIDTH  32
`define FB_HEIGHT 24

// line timing in pixel slots
`define H_FRONT 2
`define H_SYNC  4
`define H_BACK  2
`define H_TOTAL (`FB_WIDTH + `H_FRONT + `H_SYNC + `H_BACK)

// frame timing in lines
`define V_FRONT 1
`define V_SYNC  2
`define V_BACK  3
`define V_TOTAL (`FB_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK)

// per-pass channel decay and wait after the clear
`define FADE_STEP     1
`define SETTLE_CYCLES 8

`endif

// File: scope_ifs.sv
`timescale 1ns/1ps

// captured adc sample on its way to the drawing path
interface adc_sample_if;
  logic                valid;
  logic                ready;
  adc_pkg::adc_data_t  x;
  adc_pkg::adc_data_t  y;
  adc_pkg::adc_rgb_t   rgb;

  modport source(output valid, output x, output y, output rgb, input ready);
  modport sink(input valid, input x, input y, input rgb, output ready);
endinterface

// one pixel write into the framebuffer
interface gfx_pixel_if;
  logic              valid;
  logic              ready;
  gfx_pkg::fb_x_t    x;
  gfx_pkg::fb_y_t    y;
  gfx_pkg::pixel_t   color;

  modport source(
    output valid,
    output x,
    output y,
    output color,
    input  ready
  );
  modport sink(
    input  valid,
    input  x,
    input  y,
    input  color,
    output ready
  );
endinterface

// File: tb_adc_xy_scope.sv
`timescale 1ns/1ps
`include "scope_defs.svh"

module tb_adc_xy_scope;

  localparam int FRAME_CLKS   = 2 * `H_TOTAL * `V_TOTAL;
  localparam int FB_PIXELS    = `FB_WIDTH * `FB_HEIGHT;
  localparam int HS_START     = `FB_WIDTH + `H_FRONT;
  // the vsync edge opens the line after the front porch
  localparam int VS_LINE      = `FB_HEIGHT + `V_FRONT;
  localparam int STROBE_FIRST = 4;
  localparam int STROBE_GAP   = 6;
  // an odd cycle in line 0 makes the sample wait out a write-back
  localparam int REDRAW_AT    = 2 * (`V_TOTAL - VS_LINE) * `H_TOTAL + 1;

  typedef struct packed {
    adc_pkg::adc_data_t ax;
    adc_pkg::adc_data_t ay;
    adc_pkg::adc_rgb_t  rgb;
    logic [7:0]         frames;
    logic               drop;
    gfx_pkg::fb_x_t     ex;
    gfx_pkg::fb_y_t     ey;
    gfx_pkg::pixel_t    pix;
  } test_rec_t;

  logic               clk;
  logic               reset;
  adc_pkg::adc_data_t adc_x;
  adc_pkg::adc_data_t adc_y;
  adc_pkg::adc_rgb_t  adc_rgb;
  logic               adc_strobe;
  gfx_pkg::channel_t  vga_red;
  gfx_pkg::channel_t  vga_grn;
  gfx_pkg::channel_t  vga_blu;
  logic               vga_hsync;
  logic               vga_vsync;
  logic               vsync_q;

  test_rec_t       recs[$];
  test_rec_t       pend[$];
  gfx_pkg::pixel_t model [FB_PIXELS];
  int              limit_cycles = 0;

  adc_xy_scope dut (
    .clk        (clk),
    .reset      (reset),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_rgb    (adc_rgb),
    .adc_strobe (adc_strobe),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  bind adc_xy_scope adc_xy_scope_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .draw_valid (draw_pix.valid),
    .draw_ready (draw_pix.ready),
    .draw_x     (draw_pix.x),
    .draw_y     (draw_pix.y),
    .draw_color (draw_pix.color),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // previous output sample for edge detection
  always @(negedge clk) begin
    vsync_q <= vga_vsync;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout, the run did not finish within %0d clock cycles", limit_cycles);
    $display("Simulation FAILED");
    $fatal(1);
  end

  task automatic check_pixel(string name, gfx_pkg::pixel_t got, gfx_pkg::pixel_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_sync(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // one scan pass takes FADE_STEP off each channel but never goes below zero
  function automatic gfx_pkg::pixel_t dim_pixel(gfx_pkg::pixel_t p);
    gfx_pkg::channel_t ch;
    gfx_pkg::pixel_t   q;
    for (int c = 0; c < 3; c++) begin
      ch = p[4*c +: 4];
      q[4*c +: 4] = (ch > gfx_pkg::channel_t'(`FADE_STEP)) ?
                    ch - gfx_pkg::channel_t'(`FADE_STEP) : 4'h0;
    end
    return q;
  endfunction

  task automatic load_tests();
    int        fd;
    int        n;
    int        v [8];
    string     line;
    test_rec_t rec;
    fd = $fopen("adc_xy_scope_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open adc_xy_scope_tests.txt");
      $display("Simulation FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
        if (n == 8) begin
          rec.ax     = adc_pkg::adc_data_t'(v[0]);
          rec.ay     = adc_pkg::adc_data_t'(v[1]);
          rec.rgb    = adc_pkg::adc_rgb_t'(v[2]);
          rec.frames = 8'(v[3]);
          rec.drop   = v[4] != 0;
          rec.ex     = gfx_pkg::fb_x_t'(v[5]);
          rec.ey     = gfx_pkg::fb_y_t'(v[6]);
          rec.pix    = gfx_pkg::pixel_t'(v[7]);
          recs.push_back(rec);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_vsync_fall();
    do begin
      @(negedge clk);
    end while (!(vsync_q === 1'b1 && vga_vsync === 1'b0));
  endtask

  // follows the outputs from a vsync edge with two samples per pixel slot
  task automatic scan_frames(int frames);
    int              pos;
    int              h;
    int              v;
    int              k;
    int              redraw;
    gfx_pkg::pixel_t exp_pix;
    // last drawn sample below line 0 is sent again while line 0 scans
    redraw = -1;
    foreach (pend[p]) begin
      if (!pend[p].drop && pend[p].ey != 0) begin
        redraw = p;
      end
    end
    wait_vsync_fall();
    for (int i = 0; i < frames * FRAME_CLKS; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      pos = (i / 2) % (`H_TOTAL * `V_TOTAL);
      h   = pos % `H_TOTAL;
      v   = (VS_LINE + pos / `H_TOTAL) % `V_TOTAL;
      check_sync("vga_hsync", vga_hsync, !(h >= HS_START && h < HS_START + `H_SYNC));
      check_sync("vga_vsync", vga_vsync, !(v >= VS_LINE && v < VS_LINE + `V_SYNC));
      exp_pix = '0;
      if (h < `FB_WIDTH && v < `FB_HEIGHT) begin
        exp_pix = model[v * `FB_WIDTH + h];
      end
      check_pixel($sformatf("vga_rgb at x=%0d y=%0d", h, v),
                  {vga_red, vga_grn, vga_blu}, exp_pix);
      // pending samples go out early in the first blanking
      k = (i - STROBE_FIRST) / STROBE_GAP;
      @(posedge clk);
      if (i >= STROBE_FIRST && (i - STROBE_FIRST) % STROBE_GAP == 0 && k < pend.size()) begin
        adc_x      <= pend[k].ax;
        adc_y      <= pend[k].ay;
        adc_rgb    <= pend[k].rgb;
        adc_strobe <= 1'b1;
      end else if (i == REDRAW_AT && redraw >= 0) begin
        // rewrites a pixel that this frame has not scanned yet
        adc_x      <= pend[redraw].ax;
        adc_y      <= pend[redraw].ay;
        adc_rgb    <= pend[redraw].rgb;
        adc_strobe <= 1'b1;
      end else begin
        adc_strobe <= 1'b0;
      end
      if (i % FRAME_CLKS == FRAME_CLKS - 1) begin
        foreach (model[a]) model[a] = dim_pixel(model[a]);
      end
    end
  endtask

  initial begin
    int limit;
    reset      <= 1'b1;
    adc_x      <= '0;
    adc_y      <= '0;
    adc_rgb    <= '0;
    adc_strobe <= 1'b0;
    foreach (model[a]) model[a] = '0;
    load_tests();
    if (recs.size() == 0) begin
      $display("The test file holds no records");
      $display("Simulation FAILED");
      $fatal(1);
    end
    // two extra frames cover startup
    limit = 2 * FRAME_CLKS;
    foreach (recs[r]) limit += (recs[r].frames + 2) * FRAME_CLKS;
    limit_cycles = limit;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // display stays dark while the clear runs
    repeat (FB_PIXELS) begin
      @(negedge clk);
      check_sync("vga_hsync", vga_hsync, 1'b1);
      check_sync("vga_vsync", vga_vsync, 1'b1);
      check_pixel("vga_rgb", {vga_red, vga_grn, vga_blu}, '0);
    end
    scan_frames(1);
    // frames 0 groups a sample with the next record
    foreach (recs[r]) begin
      pend.push_back(recs[r]);
      if (recs[r].frames != 0) begin
        foreach (pend[k]) begin
          if (!pend[k].drop) begin
            model[int'(pend[k].ey) * `FB_WIDTH + int'(pend[k].ex)] = pend[k].pix;
          end
        end
        scan_frames(recs[r].frames);
        pend.delete();
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule
